// File: files.f
hw/dec_pkg.sv
hw/inst_decoder.sv
hw/imm_gen.sv
hw/dispatch_ctrl.sv
hw/d2e_regs.sv
hw/ifu_dec.sv
testbench/tb_ifu_dec.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ifu_dec testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f files.f --top-module tb_ifu_dec -o tb_ifu_dec
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_ifu_dec > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ ! -f "$LOG" ]; then
   echo "no simulation log written"
   exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
   echo "simulation reported a failure"
   exit 1
fi

if [ $sim_status -ne 0 ]; then
   echo "simulator exited with status $sim_status"
   exit 1
fi

echo "simulation finished without errors"
exit 0

// File: testbench/tb_ifu_dec.sv
`default_nettype none

module tb_ifu_dec import dec_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   typedef struct packed {
      word_t     inst;
      word_t     pc;
      logic      valid;
      // rs1/rs2 only checked where both matter
      logic      rs_chk;
      reg_addr_t rs1;
      reg_addr_t rs2;
      alu_req_t  alu;
      lsu_req_t  lsu;
      bru_req_t  bru;
      mul_req_t  mul;
      exc_t      exc;
   } entry_t;

   logic      clk = 1'b0;
   logic      rst;
   word_t     inst;
   word_t     pc;
   logic      inst_valid;
   reg_addr_t rs1;
   reg_addr_t rs2;
   word_t     rs1_data;
   word_t     rs2_data;
   alu_req_t  alu_e;
   lsu_req_t  lsu_e;
   bru_req_t  bru_e;
   mul_req_t  mul_e;
   exc_t      exc_e;

   word_t       rf [32];
   entry_t      stim_q [$];
   word_t       next_pc;
   int          i;

   always #5 clk = ~clk;

   // register file model, answers in the same cycle
   assign rs1_data = rf[rs1];
   assign rs2_data = rf[rs2];

   ifu_dec ifu_dec_i (
      .clk        (clk),
      .rst        (rst),
      .inst       (inst),
      .pc         (pc),
      .inst_valid (inst_valid),
      .rs1        (rs1),
      .rs2        (rs2),
      .rs1_data   (rs1_data),
      .rs2_data   (rs2_data),
      .alu_e      (alu_e),
      .lsu_e      (lsu_e),
      .bru_e      (bru_e),
      .mul_e      (mul_e),
      .exc_e      (exc_e)
   );

   //////////////////////////////
   // instruction encoders
   //////////////////////////////

   function automatic word_t r3_word(logic [16:0] opc, reg_addr_t rk, reg_addr_t rj,
                                     reg_addr_t rd);
      return {opc, rk, rj, rd};
   endfunction

   function automatic word_t ri12_word(logic [9:0] opc, logic [11:0] si12, reg_addr_t rj,
                                       reg_addr_t rd);
      return {opc, si12, rj, rd};
   endfunction

   function automatic word_t br16_word(logic [5:0] opc, logic [15:0] offs, reg_addr_t rj,
                                       reg_addr_t rd);
      return {opc, offs, rj, rd};
   endfunction

   // offs26 is split, low half first
   function automatic word_t br26_word(logic [5:0] opc, logic [25:0] offs);
      return {opc, offs[15:0], offs[25:16]};
   endfunction

   //////////////////////////////
   // expected requests
   //////////////////////////////

   function automatic alu_req_t alu_issue(alu_op_e op, word_t a, word_t b, logic b_imm,
                                          reg_addr_t target);
      alu_req_t r;
      r.valid  = 1'b1;
      r.op     = op;
      r.a      = a;
      r.b      = b;
      r.b_imm  = b_imm;
      r.wen    = 1'b1;
      r.target = target;
      return r;
   endfunction

   function automatic alu_req_t alu_idle(reg_addr_t target);
      alu_req_t r;
      r        = '0;
      r.target = target;
      return r;
   endfunction

   function automatic lsu_req_t lsu_issue(lsu_op_e op, word_t imm, reg_addr_t rd, logic wen);
      lsu_req_t r;
      r.valid = 1'b1;
      r.op    = op;
      r.imm   = imm;
      r.rd    = rd;
      r.wen   = wen;
      return r;
   endfunction

   function automatic lsu_req_t lsu_idle();
      lsu_req_t r;
      r = '0;
      return r;
   endfunction

   function automatic bru_req_t bru_issue(bru_op_e op, word_t offset);
      bru_req_t r;
      r.valid  = 1'b1;
      r.op     = op;
      r.offset = offset;
      return r;
   endfunction

   function automatic bru_req_t bru_idle();
      bru_req_t r;
      r = '0;
      return r;
   endfunction

   function automatic mul_req_t mul_issue(logic sgn, logic hi, reg_addr_t target);
      mul_req_t r;
      r.valid     = 1'b1;
      r.is_signed = sgn;
      r.hi        = hi;
      r.wen       = 1'b1;
      r.target    = target;
      return r;
   endfunction

   function automatic mul_req_t mul_idle(reg_addr_t target);
      mul_req_t r;
      r        = '0;
      r.target = target;
      return r;
   endfunction

   function automatic exc_t trap(exccode_e code);
      exc_t r;
      r.flag = (code != exc_none);
      r.code = code;
      return r;
   endfunction

   task automatic add_step(word_t inst_w, logic valid, logic rs_chk, reg_addr_t rs1_x,
                           reg_addr_t rs2_x, alu_req_t alu, lsu_req_t lsu, bru_req_t bru,
                           mul_req_t mul, exc_t exc);
      entry_t e;
      e.inst   = inst_w;
      e.pc     = next_pc;
      e.valid  = valid;
      e.rs_chk = rs_chk;
      e.rs1    = rs1_x;
      e.rs2    = rs2_x;
      e.alu    = alu;
      e.lsu    = lsu;
      e.bru    = bru;
      e.mul    = mul;
      e.exc    = exc;
      stim_q.push_back(e);
      next_pc = next_pc + 32'd4;
   endtask

   //////////////////////////////
   // checks
   //////////////////////////////

   task automatic stop_failed();
      $display("*** TEST FAILED ***");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic compare_field(string name, logic [31:0] exp, logic [31:0] act);
      if (act !== exp) begin
         $display("error t=%0t %s expected %h got %h", $time, name, exp, act);
         stop_failed();
      end
   endtask

   task automatic check_addr(string name, reg_addr_t exp, reg_addr_t act);
      compare_field(name, 32'(exp), 32'(act));
   endtask

   // payload fields only matter with valid set
   task automatic check_alu(alu_req_t exp, alu_req_t act);
      compare_field("alu_e.valid", 32'(exp.valid), 32'(act.valid));
      compare_field("alu_e.wen", 32'(exp.wen), 32'(act.wen));
      compare_field("alu_e.b_imm", 32'(exp.b_imm), 32'(act.b_imm));
      compare_field("alu_e.target", 32'(exp.target), 32'(act.target));
      if (exp.valid) begin
         compare_field("alu_e.op", 32'(exp.op), 32'(act.op));
         compare_field("alu_e.a", exp.a, act.a);
         compare_field("alu_e.b", exp.b, act.b);
      end
   endtask

   task automatic check_lsu(lsu_req_t exp, lsu_req_t act);
      compare_field("lsu_e.valid", 32'(exp.valid), 32'(act.valid));
      compare_field("lsu_e.wen", 32'(exp.wen), 32'(act.wen));
      if (exp.valid) begin
         compare_field("lsu_e.op", 32'(exp.op), 32'(act.op));
         compare_field("lsu_e.imm", exp.imm, act.imm);
         compare_field("lsu_e.rd", 32'(exp.rd), 32'(act.rd));
      end
   endtask

   task automatic check_bru(bru_req_t exp, bru_req_t act);
      compare_field("bru_e.valid", 32'(exp.valid), 32'(act.valid));
      if (exp.valid) begin
         compare_field("bru_e.op", 32'(exp.op), 32'(act.op));
         compare_field("bru_e.offset", exp.offset, act.offset);
      end
   endtask

   task automatic check_mul(mul_req_t exp, mul_req_t act);
      compare_field("mul_e.valid", 32'(exp.valid), 32'(act.valid));
      compare_field("mul_e.wen", 32'(exp.wen), 32'(act.wen));
      compare_field("mul_e.target", 32'(exp.target), 32'(act.target));
      if (exp.valid) begin
         compare_field("mul_e.is_signed", 32'(exp.is_signed), 32'(act.is_signed));
         compare_field("mul_e.hi", 32'(exp.hi), 32'(act.hi));
      end
   endtask

   task automatic check_exc(exc_t exp, exc_t act);
      compare_field("exc_e.flag", 32'(exp.flag), 32'(act.flag));
      if (exp.flag) begin
         compare_field("exc_e.code", 32'(exp.code), 32'(act.code));
      end
   endtask

   // control bits that reset must clear
   task automatic check_reset_state();
      compare_field("alu_e.valid", 32'h0, 32'(alu_e.valid));
      compare_field("alu_e.wen", 32'h0, 32'(alu_e.wen));
      compare_field("lsu_e.valid", 32'h0, 32'(lsu_e.valid));
      compare_field("lsu_e.wen", 32'h0, 32'(lsu_e.wen));
      compare_field("bru_e.valid", 32'h0, 32'(bru_e.valid));
      compare_field("mul_e.valid", 32'h0, 32'(mul_e.valid));
      compare_field("mul_e.wen", 32'h0, 32'(mul_e.wen));
      compare_field("exc_e.flag", 32'h0, 32'(exc_e.flag));
   endtask

   task automatic wait_idle();
      int cycles;
      cycles = 0;
      @(negedge clk);
      while ((alu_e.valid | lsu_e.valid | bru_e.valid | mul_e.valid | exc_e.flag) !== 1'b0)
      begin
         if (cycles == 20) begin
            $display("valid flags still set 20 cycles after reset");
            stop_failed();
         end
         @(negedge clk);
         cycles++;
      end
   endtask

   //////////////////////////////
   // stimulus table
   //////////////////////////////

   task automatic build_table();
      next_pc = 32'h1c00_0000;
      // register ALU ops
      add_step(r3_word(opc_add_w, 5'd12, 5'd5, 5'd3), 1'b1, 1'b1, 5'd5, 5'd12,
         alu_issue(alu_add, rf[5], rf[12], 1'b0, 5'd3), lsu_idle(), bru_idle(),
         mul_idle(5'd3), trap(exc_none));
      add_step(r3_word(opc_sub_w, 5'd20, 5'd7, 5'd4), 1'b1, 1'b1, 5'd7, 5'd20,
         alu_issue(alu_sub, rf[7], rf[20], 1'b0, 5'd4), lsu_idle(), bru_idle(),
         mul_idle(5'd4), trap(exc_none));
      add_step(r3_word(opc_and, 5'd10, 5'd9, 5'd6), 1'b1, 1'b1, 5'd9, 5'd10,
         alu_issue(alu_and, rf[9], rf[10], 1'b0, 5'd6), lsu_idle(), bru_idle(),
         mul_idle(5'd6), trap(exc_none));
      add_step(r3_word(opc_or, 5'd13, 5'd11, 5'd8), 1'b1, 1'b1, 5'd11, 5'd13,
         alu_issue(alu_or, rf[11], rf[13], 1'b0, 5'd8), lsu_idle(), bru_idle(),
         mul_idle(5'd8), trap(exc_none));
      add_step(r3_word(opc_xor, 5'd5, 5'd30, 5'd31), 1'b1, 1'b1, 5'd30, 5'd5,
         alu_issue(alu_xor, rf[30], rf[5], 1'b0, 5'd31), lsu_idle(), bru_idle(),
         mul_idle(5'd31), trap(exc_none));
      // immediate ALU, one negative si12
      add_step(ri12_word(opc_addi_w, 12'h123, 5'd5, 5'd2), 1'b1, 1'b0, 5'd0, 5'd0,
         alu_issue(alu_add, rf[5], 32'h0000_0123, 1'b1, 5'd2), lsu_idle(), bru_idle(),
         mul_idle(5'd2), trap(exc_none));
      add_step(ri12_word(opc_addi_w, 12'hf80, 5'd12, 5'd9), 1'b1, 1'b0, 5'd0, 5'd0,
         alu_issue(alu_add, rf[12], 32'hffff_ff80, 1'b1, 5'd9), lsu_idle(), bru_idle(),
         mul_idle(5'd9), trap(exc_none));
      add_step({opc_pcaddu12i, 20'h12345, 5'd10}, 1'b1, 1'b0, 5'd0, 5'd0,
         alu_issue(alu_add, next_pc, 32'h1234_5000, 1'b1, 5'd10), lsu_idle(), bru_idle(),
         mul_idle(5'd10), trap(exc_none));
      // loads and stores
      add_step(ri12_word(opc_ld_w, 12'h7fc, 5'd3, 5'd14), 1'b1, 1'b0, 5'd0, 5'd0,
         alu_idle(5'd14), lsu_issue(lsu_ld_w, 32'h0000_07fc, 5'd14, 1'b1), bru_idle(),
         mul_idle(5'd14), trap(exc_none));
      add_step(ri12_word(opc_st_w, 12'hff8, 5'd3, 5'd15), 1'b1, 1'b1, 5'd3, 5'd15,
         alu_idle(5'd15), lsu_issue(lsu_st_w, 32'hffff_fff8, 5'd15, 1'b0), bru_idle(),
         mul_idle(5'd15), trap(exc_none));
      // branches
      add_step(br16_word(opc_beq, 16'h0010, 5'd4, 5'd6), 1'b1, 1'b1, 5'd4, 5'd6,
         alu_idle(5'd6), lsu_idle(), bru_issue(bru_beq, 32'h0000_0040),
         mul_idle(5'd6), trap(exc_none));
      add_step(br16_word(opc_bne, 16'hfffe, 5'd8, 5'd9), 1'b1, 1'b1, 5'd8, 5'd9,
         alu_idle(5'd9), lsu_idle(), bru_issue(bru_bne, 32'hffff_fff8),
         mul_idle(5'd9), trap(exc_none));
      add_step(br26_word(opc_b, 26'h000_0400), 1'b1, 1'b0, 5'd0, 5'd0,
         alu_idle(5'd0), lsu_idle(), bru_issue(bru_b, 32'h0000_1000),
         mul_idle(5'd0), trap(exc_none));
      // bl links into r1
      add_step(br26_word(opc_bl, 26'h3ff_ffff), 1'b1, 1'b0, 5'd0, 5'd0,
         alu_idle(5'd1), lsu_idle(), bru_issue(bru_bl, 32'hffff_fffc),
         mul_idle(5'd1), trap(exc_none));
      // multiply
      add_step(r3_word(opc_mul_w, 5'd18, 5'd17, 5'd16), 1'b1, 1'b1, 5'd17, 5'd18,
         alu_idle(5'd16), lsu_idle(), bru_idle(), mul_issue(1'b1, 1'b0, 5'd16),
         trap(exc_none));
      add_step(r3_word(opc_mulh_w, 5'd21, 5'd20, 5'd19), 1'b1, 1'b1, 5'd20, 5'd21,
         alu_idle(5'd19), lsu_idle(), bru_idle(), mul_issue(1'b1, 1'b1, 5'd19),
         trap(exc_none));
      add_step(r3_word(opc_mulh_wu, 5'd24, 5'd23, 5'd22), 1'b1, 1'b1, 5'd23, 5'd24,
         alu_idle(5'd22), lsu_idle(), bru_idle(), mul_issue(1'b0, 1'b1, 5'd22),
         trap(exc_none));
      // traps and unknown encodings
      add_step({opc_syscall, 15'd0}, 1'b1, 1'b0, 5'd0, 5'd0,
         alu_idle(5'd0), lsu_idle(), bru_idle(), mul_idle(5'd0), trap(exc_sys));
      add_step({opc_break, 15'd5}, 1'b1, 1'b0, 5'd0, 5'd0,
         alu_idle(5'd5), lsu_idle(), bru_idle(), mul_idle(5'd5), trap(exc_brk));
      add_step(32'hffff_ffff, 1'b1, 1'b0, 5'd0, 5'd0,
         alu_idle(5'd31), lsu_idle(), bru_idle(), mul_idle(5'd31), trap(exc_ine));
      // inst_valid low, register ports still follow inst
      add_step(r3_word(opc_add_w, 5'd2, 5'd1, 5'd7), 1'b0, 1'b1, 5'd1, 5'd2,
         alu_idle(5'd7), lsu_idle(), bru_idle(), mul_idle(5'd7), trap(exc_none));
      add_step(32'hffff_ffff, 1'b0, 1'b0, 5'd0, 5'd0,
         alu_idle(5'd31), lsu_idle(), bru_idle(), mul_idle(5'd31), trap(exc_none));
      add_step(r3_word(opc_and, 5'd5, 5'd12, 5'd3), 1'b1, 1'b1, 5'd12, 5'd5,
         alu_issue(alu_and, rf[12], rf[5], 1'b0, 5'd3), lsu_idle(), bru_idle(),
         mul_idle(5'd3), trap(exc_none));
   endtask

   //////////////////////////////
   // main sequence
   //////////////////////////////

   initial begin
      for (int n = 0; n < 32; n++) begin
         rf[n] = word_t'(n) * 32'h0101_0101;
      end
      // a few registers get random data
      rf[5]  = $urandom(32'h150b_838b);
      rf[12] = $urandom;
      rf[20] = $urandom;

      // live instructions during reset must not reach execute
      rst        = 1'b1;
      inst       = r3_word(opc_add_w, 5'd2, 5'd1, 5'd7);
      pc         = '0;
      inst_valid = 1'b1;
      build_table();

      @(posedge clk);
      inst <= ri12_word(opc_ld_w, 12'h010, 5'd1, 5'd7);
      @(negedge clk);
      check_reset_state();
      @(posedge clk);
      rst        <= 1'b0;
      inst       <= '0;
      inst_valid <= 1'b0;
      @(negedge clk);
      check_reset_state();
      wait_idle();

      // one entry per cycle, outputs lag by one edge
      for (i = 0; i <= stim_q.size(); i++) begin
         @(posedge clk);
         if (i < stim_q.size()) begin
            inst       <= stim_q[i].inst;
            pc         <= stim_q[i].pc;
            inst_valid <= stim_q[i].valid;
         end else begin
            inst_valid <= 1'b0;
         end
         @(negedge clk);
         if (i < stim_q.size() && stim_q[i].rs_chk) begin
            check_addr("rs1", stim_q[i].rs1, rs1);
            check_addr("rs2", stim_q[i].rs2, rs2);
         end
         if (i > 0) begin
            check_alu(stim_q[i-1].alu, alu_e);
            check_lsu(stim_q[i-1].lsu, lsu_e);
            check_bru(stim_q[i-1].bru, bru_e);
            check_mul(stim_q[i-1].mul, mul_e);
            check_exc(stim_q[i-1].exc, exc_e);
         end
      end

      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

// File: hw/ifu_dec.sv
`default_nettype none

module ifu_dec import dec_pkg::*; (
   input  logic      clk,
   input  logic      rst,

   // fetch side
   input  word_t     inst,
   input  word_t     pc,
   input  logic      inst_valid,

   // register file, answered in the same cycle
   output reg_addr_t rs1,
   output reg_addr_t rs2,
   input  word_t     rs1_data,
   input  word_t     rs2_data,

   // execute stage
   output alu_req_t  alu_e,
   output lsu_req_t  lsu_e,
   output bru_req_t  bru_e,
   output mul_req_t  mul_e,
   output exc_t      exc_e
);

   dec_op_t  op;
   imm_t     imm;
   alu_req_t alu_d;
   lsu_req_t lsu_d;
   bru_req_t bru_d;
   mul_req_t mul_d;
   exc_t     exc_d;

   inst_decoder inst_decoder_i (
      .inst (inst),
      .op   (op)
   );

   imm_gen imm_gen_i (
      .inst (inst),
      .op   (op),
      .imm  (imm)
   );

   dispatch_ctrl dispatch_ctrl_i (
      .inst       (inst),
      .pc         (pc),
      .inst_valid (inst_valid),
      .op         (op),
      .imm        (imm),
      .rs1_data   (rs1_data),
      .rs2_data   (rs2_data),
      .rs1        (rs1),
      .rs2        (rs2),
      .alu_d      (alu_d),
      .lsu_d      (lsu_d),
      .bru_d      (bru_d),
      .mul_d      (mul_d),
      .exc_d      (exc_d)
   );

   // decode to execute boundary
   d2e_regs d2e_regs_i (
      .clk   (clk),
      .rst   (rst),
      .alu_d (alu_d),
      .lsu_d (lsu_d),
      .bru_d (bru_d),
      .mul_d (mul_d),
      .exc_d (exc_d),
      .alu_e (alu_e),
      .lsu_e (lsu_e),
      .bru_e (bru_e),
      .mul_e (mul_e),
      .exc_e (exc_e)
   );

endmodule

`default_nettype wire

// File: hw/d2e_regs.sv
`default_nettype none

module d2e_regs import dec_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  alu_req_t alu_d,
   input  lsu_req_t lsu_d,
   input  bru_req_t bru_d,
   input  mul_req_t mul_d,
   input  exc_t     exc_d,
   output alu_req_t alu_e,
   output lsu_req_t lsu_e,
   output bru_req_t bru_e,
   output mul_req_t mul_e,
   output exc_t     exc_e
);

   always_ff @(posedge clk) begin
      alu_e <= alu_d;
      lsu_e <= lsu_d;
      bru_e <= bru_d;
      mul_e <= mul_d;
      exc_e <= exc_d;

      // control bits only, payload keeps loading
      if (rst) begin
         alu_e.valid <= 1'b0;
         alu_e.wen   <= 1'b0;
         lsu_e.valid <= 1'b0;
         lsu_e.wen   <= 1'b0;
         bru_e.valid <= 1'b0;
         mul_e.valid <= 1'b0;
         mul_e.wen   <= 1'b0;
         exc_e.flag  <= 1'b0;
      end
   end

   //////////////////////////////
   // checks
   //////////////////////////////

   // single issue into execute
   a_one_unit: assert property (@(posedge clk) disable iff (rst)
      $onehot0({alu_e.valid, lsu_e.valid, bru_e.valid, mul_e.valid}))
      else $error("more than one unit valid in execute");

   // no write-back without a live request
   a_wen_valid: assert property (@(posedge clk) disable iff (rst)
      (!alu_e.wen || alu_e.valid) &&
      (!lsu_e.wen || lsu_e.valid) &&
      (!mul_e.wen || mul_e.valid))
      else $error("write enable without its unit valid");

   // a raised trap leaves all four units idle
   a_exc_idle: assert property (@(posedge clk) disable iff (rst)
      !exc_e.flag || !(alu_e.valid | lsu_e.valid | bru_e.valid | mul_e.valid))
      else $error("exception raised together with a unit valid");

endmodule

`default_nettype wire

// File: hw/dispatch_ctrl.sv
`default_nettype none

module dispatch_ctrl import dec_pkg::*; (
   input  word_t     inst,
   input  word_t     pc,
   input  logic      inst_valid,
   input  dec_op_t   op,
   input  imm_t      imm,
   input  word_t     rs1_data,
   input  word_t     rs2_data,
   output reg_addr_t rs1,
   output reg_addr_t rs2,
   output alu_req_t  alu_d,
   output lsu_req_t  lsu_d,
   output bru_req_t  bru_d,
   output mul_req_t  mul_d,
   output exc_t      exc_d
);

   reg_addr_t rd;
   reg_addr_t rj;
   reg_addr_t rk;
   reg_addr_t target;
   logic      exc_flag;
   logic      issue_ok;
   logic      is_bl;
   logic      alu_valid;
   logic      lsu_valid;
   logic      bru_valid;
   logic      mul_valid;
   logic      alu_b_imm;

   assign rd = inst[4:0];
   assign rj = inst[9:5];
   assign rk = inst[14:10];

   //////////////////////////////
   // exceptions
   //////////////////////////////

   assign exc_flag = inst_valid & (op.syscall | op.brk | op.ine);

   assign exc_d.flag = exc_flag;
   assign exc_d.code = op.syscall ? exc_sys :
                       op.brk     ? exc_brk :
                       op.ine     ? exc_ine : exc_none;

   // nothing issues alongside a trap
   assign issue_ok  = inst_valid & ~exc_flag;
   assign alu_valid = (op.unit == unit_alu) & issue_ok;
   assign lsu_valid = (op.unit == unit_lsu) & issue_ok;
   assign bru_valid = (op.unit == unit_bru) & issue_ok;
   assign mul_valid = (op.unit == unit_mul) & issue_ok;

   //////////////////////////////
   // register file ports
   //////////////////////////////

   assign rs1 = rj;
   assign rs2 = op.rd_read ? rd : rk;

   // bl links into r1
   assign is_bl  = (op.unit == unit_bru) && (op.bru_op == bru_bl);
   assign target = is_bl ? 5'd1 : rd;

   //////////////////////////////
   // unit requests
   //////////////////////////////

   assign alu_b_imm = ((op.imm_kind == imm_si12) | (op.imm_kind == imm_si20)) & alu_valid;

   assign alu_d.valid  = alu_valid;
   assign alu_d.op     = op.alu_op;
   assign alu_d.a      = op.pc_rel ? pc : rs1_data;
   assign alu_d.b      = alu_b_imm ? imm.imm_shifted : rs2_data;
   assign alu_d.b_imm  = alu_b_imm;
   assign alu_d.wen    = op.rf_wen & alu_valid;
   assign alu_d.target = target;

   assign lsu_d.valid = lsu_valid;
   assign lsu_d.op    = op.lsu_op;
   assign lsu_d.imm   = imm.imm_shifted;
   assign lsu_d.rd    = target;
   assign lsu_d.wen   = op.rf_wen & lsu_valid;

   assign bru_d.valid  = bru_valid;
   assign bru_d.op     = op.bru_op;
   assign bru_d.offset = imm.br_offs;

   assign mul_d.valid     = mul_valid;
   assign mul_d.is_signed = op.mul_signed;
   assign mul_d.hi        = op.mul_hi;
   assign mul_d.wen       = op.rf_wen & mul_valid;
   assign mul_d.target    = target;

endmodule

`default_nettype wire

// File: hw/imm_gen.sv
`default_nettype none

module imm_gen import dec_pkg::*; (
   input  word_t   inst,
   input  dec_op_t op,
   output imm_t    imm
);

   word_t si12_sext;
   word_t si20_shifted;
   word_t offs16_sext;
   word_t offs26_sext;

   assign si12_sext    = {{20{inst[21]}}, inst[21:10]};
   assign si20_shifted = {inst[24:5], 12'b0};

   // word offsets, scaled by 4
   assign offs16_sext  = {{14{inst[25]}}, inst[25:10], 2'b00};
   // offs26 high part sits in inst[9:0]
   assign offs26_sext  = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

   always_comb begin
      imm = '0;
      case (op.imm_kind)
         imm_si12:   imm.imm_shifted = si12_sext;
         imm_si20:   imm.imm_shifted = si20_shifted;
         imm_offs16: imm.br_offs = offs16_sext;
         imm_offs26: imm.br_offs = offs26_sext;
         default:    imm = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: hw/inst_decoder.sv
`default_nettype none

module inst_decoder import dec_pkg::*; (
   input  word_t   inst,
   output dec_op_t op
);

   always_comb begin
      op = '0;
      priority case (1'b1)
         // register alu ops
         (inst[31:15] == opc_add_w): begin
            op.alu_op = alu_add;
            op.rf_wen = 1'b1;
         end
         (inst[31:15] == opc_sub_w): begin
            op.alu_op = alu_sub;
            op.rf_wen = 1'b1;
         end
         (inst[31:15] == opc_and): begin
            op.alu_op = alu_and;
            op.rf_wen = 1'b1;
         end
         (inst[31:15] == opc_or): begin
            op.alu_op = alu_or;
            op.rf_wen = 1'b1;
         end
         (inst[31:15] == opc_xor): begin
            op.alu_op = alu_xor;
            op.rf_wen = 1'b1;
         end
         // multiply
         (inst[31:15] == opc_mul_w): begin
            op.unit       = unit_mul;
            op.mul_signed = 1'b1;
            op.rf_wen     = 1'b1;
         end
         (inst[31:15] == opc_mulh_w): begin
            op.unit       = unit_mul;
            op.mul_signed = 1'b1;
            op.mul_hi     = 1'b1;
            op.rf_wen     = 1'b1;
         end
         (inst[31:15] == opc_mulh_wu): begin
            op.unit   = unit_mul;
            op.mul_hi = 1'b1;
            op.rf_wen = 1'b1;
         end
         // traps, code field ignored
         (inst[31:15] == opc_syscall): op.syscall = 1'b1;
         (inst[31:15] == opc_break):   op.brk = 1'b1;
         // immediate forms
         (inst[31:22] == opc_addi_w): begin
            op.imm_kind = imm_si12;
            op.rf_wen   = 1'b1;
         end
         (inst[31:22] == opc_ld_w): begin
            op.unit     = unit_lsu;
            op.lsu_op   = lsu_ld_w;
            op.imm_kind = imm_si12;
            op.rf_wen   = 1'b1;
         end
         (inst[31:22] == opc_st_w): begin
            op.unit     = unit_lsu;
            op.lsu_op   = lsu_st_w;
            op.imm_kind = imm_si12;
            op.rd_read  = 1'b1;
         end
         (inst[31:25] == opc_pcaddu12i): begin
            op.imm_kind = imm_si20;
            op.pc_rel   = 1'b1;
            op.rf_wen   = 1'b1;
         end
         // branches
         (inst[31:26] == opc_beq): begin
            op.unit     = unit_bru;
            op.bru_op   = bru_beq;
            op.imm_kind = imm_offs16;
            op.rd_read  = 1'b1;
         end
         (inst[31:26] == opc_bne): begin
            op.unit     = unit_bru;
            op.bru_op   = bru_bne;
            op.imm_kind = imm_offs16;
            op.rd_read  = 1'b1;
         end
         (inst[31:26] == opc_b): begin
            op.unit     = unit_bru;
            op.bru_op   = bru_b;
            op.imm_kind = imm_offs26;
         end
         (inst[31:26] == opc_bl): begin
            op.unit     = unit_bru;
            op.bru_op   = bru_bl;
            op.imm_kind = imm_offs26;
            op.rf_wen   = 1'b1;
         end
         default: op.ine = 1'b1;
      endcase
   end

endmodule

`default_nettype wire

// File: hw/dec_pkg.sv
`default_nettype none

package dec_pkg;

   localparam int xlen = 32;

   typedef logic [4:0]      reg_addr_t;
   typedef logic [xlen-1:0] word_t;

   //////////////////////////////
   // LA32 encodings
   //////////////////////////////

   // 3R group, inst[31:15]
   localparam logic [16:0] opc_add_w   = 17'h00020;
   localparam logic [16:0] opc_sub_w   = 17'h00022;
   localparam logic [16:0] opc_and     = 17'h00029;
   localparam logic [16:0] opc_or      = 17'h0002a;
   localparam logic [16:0] opc_xor     = 17'h0002b;
   localparam logic [16:0] opc_mul_w   = 17'h00038;
   localparam logic [16:0] opc_mulh_w  = 17'h00039;
   localparam logic [16:0] opc_mulh_wu = 17'h0003a;
   localparam logic [16:0] opc_break   = 17'h00054;
   localparam logic [16:0] opc_syscall = 17'h00056;

   // 2RI12 group, inst[31:22]
   localparam logic [9:0]  opc_addi_w  = 10'h00a;
   localparam logic [9:0]  opc_ld_w    = 10'h0a2;
   localparam logic [9:0]  opc_st_w    = 10'h0a6;

   // 1RI20, inst[31:25]
   localparam logic [6:0]  opc_pcaddu12i = 7'h0e;

   // branches, inst[31:26]
   localparam logic [5:0]  opc_beq     = 6'h16;
   localparam logic [5:0]  opc_bne     = 6'h17;
   localparam logic [5:0]  opc_b       = 6'h14;
   localparam logic [5:0]  opc_bl      = 6'h15;

   //////////////////////////////
   // decoded fields
   //////////////////////////////

   typedef enum logic [1:0] {unit_alu, unit_lsu, unit_bru, unit_mul} unit_e;
   typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_xor} alu_op_e;
   typedef enum logic       {lsu_ld_w, lsu_st_w} lsu_op_e;
   typedef enum logic [1:0] {bru_beq, bru_bne, bru_b, bru_bl} bru_op_e;
   typedef enum logic [2:0] {imm_none, imm_si12, imm_si20, imm_offs16, imm_offs26} imm_kind_e;

   typedef enum logic [5:0] {
      exc_none = 6'd0,
      exc_sys  = 6'd11,
      exc_brk  = 6'd12,
      exc_ine  = 6'd13
   } exccode_e;

   typedef struct packed {
      unit_e     unit;
      alu_op_e   alu_op;
      lsu_op_e   lsu_op;
      bru_op_e   bru_op;
      logic      mul_signed;
      logic      mul_hi;
      imm_kind_e imm_kind;
      // operand a comes from pc
      logic      pc_rel;
      // rs2 reads rd instead of rk
      logic      rd_read;
      logic      rf_wen;
      logic      syscall;
      logic      brk;
      logic      ine;
   } dec_op_t;

   typedef struct packed {
      word_t imm_shifted;
      word_t br_offs;
   } imm_t;

   //////////////////////////////
   // execute stage requests
   //////////////////////////////

   typedef struct packed {
      logic      valid;
      alu_op_e   op;
      word_t     a;
      word_t     b;
      logic      b_imm;
      logic      wen;
      reg_addr_t target;
   } alu_req_t;

   typedef struct packed {
      logic      valid;
      lsu_op_e   op;
      word_t     imm;
      reg_addr_t rd;
      logic      wen;
   } lsu_req_t;

   typedef struct packed {
      logic    valid;
      bru_op_e op;
      word_t   offset;
   } bru_req_t;

   typedef struct packed {
      logic      valid;
      logic      is_signed;
      logic      hi;
      logic      wen;
      reg_addr_t target;
   } mul_req_t;

   typedef struct packed {
      logic     flag;
      exccode_e code;
   } exc_t;

endpackage

`default_nettype wire
